// File: vlog.f
+incdir+include
source/slave_agent_pkg.sv
source/sync_fifo.sv
source/cmd_decoder.sv
source/rsp_builder.sv
source/slave_agent.sv
tests/slave_agent_asserts.sv
tests/slave_agent_tb.sv

// File: Makefile
# Verilator build and run for the slave agent testbench

VERILATOR  ?= verilator
TOP        ?= slave_agent_tb
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
SEED_LOG   ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

PASS_MSG = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the log holds the pass message
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(SEED_LOG)
	grep -qF '$(PASS_MSG)' $(SEED_LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)

// File: tests/slave_agent_tb.sv
`default_nettype none

`include "slave_agent_settings.svh"

module slave_agent_tb
    import slave_agent_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_CMDS      = 600;
    localparam int          MEM_WORDS     = 64;
    localparam int          SEND_TIMEOUT  = 20000;
    localparam int          DRAIN_TIMEOUT = 2000;
    localparam logic [31:0] SEED          = 32'd19138;

    logic                  clk;
    logic                  rst_n;
    logic                  cp_valid;
    cmd_pkt_t              cp_data;
    logic                  cp_ready;
    mm_cmd_t               m0;
    logic                  m0_waitrequest;
    logic [`SA_DATA_W-1:0] m0_readdata;
    logic                  m0_readdatavalid;
    logic                  rp_valid;
    rsp_pkt_t              rp_data;
    logic                  rp_ready;

    // slave memory and the queues of pending read data, due cycles and expected responses
    logic [`SA_DATA_W-1:0] mem [MEM_WORDS];
    logic [`SA_DATA_W-1:0] rd_data_q [$];
    int                    rd_due_q [$];
    rsp_pkt_t              exp_q [$];
    logic [31:0]           rng_state;
    bit                    cmd_taken;
    int                    last_due;
    int                    cycle_count;
    int                    sent_count;
    int                    accepted_count;
    int                    response_count;
    int                    read_count;
    int                    nonposted_count;
    int                    posted_count;
    int                    suppressed_count;
    int                    mismatch_count;
    int                    failure_count;
    int                    timeout_count;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    slave_agent dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .cp_valid         (cp_valid),
        .cp_data          (cp_data),
        .cp_ready         (cp_ready),
        .m0               (m0),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdata      (m0_readdata),
        .m0_readdatavalid (m0_readdatavalid),
        .rp_valid         (rp_valid),
        .rp_data          (rp_data),
        .rp_ready         (rp_ready)
    );

    // port names on the right are resolved inside slave_agent
    bind slave_agent slave_agent_asserts u_asserts (
        .clk      (clk),
        .rst_n    (rst_n),
        .m0       (m0),
        .rp_valid (rp_valid),
        .rp_ready (rp_ready),
        .rp_data  (rp_data),
        .rd_push  (m0_readdatavalid),
        .rd_full  (rd_full)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    // 32-bit xorshift generator that supplies every random value in the bench
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic cmd_pkt_t random_cmd();
        cmd_pkt_t    cmd;
        logic [31:0] r;
        r = next_rand();
        case (r % 3)
            0:       cmd.kind = OP_READ;
            1:       cmd.kind = OP_WRITE_POSTED;
            default: cmd.kind = OP_WRITE_NONPOSTED;
        endcase
        // keep the byte address inside the 64-word memory and leave its low bits random
        cmd.addr      = '0;
        cmd.addr[7:0] = r[15:8];
        // one command in eight carries no byte enable at all
        cmd.byteen = r[16 +: `SA_BE_W];
        if (r[22:20] == 3'd0) begin
            cmd.byteen = '0;
        end else if (cmd.byteen == '0) begin
            cmd.byteen = '1;
        end
        cmd.src_id  = r[25:23];
        cmd.dest_id = r[28:26];
        cmd.data    = next_rand();
        return cmd;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_condition(input logic cond, input string what);
        assert (cond) else begin
            failure_count++;
            $display("%s", what);
        end
    endtask

    // ------------------------------------------------------------
    // slave model and m0 checks
    // ------------------------------------------------------------

    task automatic check_slave_side();
        logic [`SA_ADDR_W-1:0] exp_addr;
        logic [5:0]            word;
        int                    due;
        int                    b;
        word = m0.address[7:2];
        if (m0.read || m0.write) begin
            check_condition(cp_valid, "m0 request issued without a command");
            check_condition(cp_data.byteen != '0, "zero byte enable command reached m0");
            exp_addr = cp_data.addr;
            exp_addr[`SA_MASK_BITS-1:0] = '0;
            compare_value("m0.address", m0.address, exp_addr);
            compare_value("m0.byteenable", m0.byteenable, cp_data.byteen);
            if (m0.write) begin
                compare_value("m0.writedata", m0.writedata, cp_data.data);
            end
        end
        // a write lands byte by byte and only where its enable is set
        if (m0.write && !m0_waitrequest) begin
            for (b = 0; b < `SA_BE_W; b++) begin
                if (m0.byteenable[b]) begin
                    mem[word][8*b +: 8] = m0.writedata[8*b +: 8];
                end
            end
        end
        // read data comes back in order after 1 to 3 cycles with at most one word per cycle
        if (m0.read && !m0_waitrequest) begin
            due = cycle_count + 1 + int'(next_rand() % 3);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rd_data_q.push_back(mem[word]);
            rd_due_q.push_back(due);
        end
    endtask

    // ------------------------------------------------------------
    // command acceptance and response model
    // ------------------------------------------------------------

    // the outstanding expected responses are exactly the tokens held in the
    // token FIFO, and only a command that reaches the slave waits for m0
    task automatic check_ready();
        logic exp_ready;
        if (cp_valid) begin
            exp_ready = (exp_q.size() < `SA_FIFO_DEPTH) &&
                        (!m0_waitrequest || cp_data.byteen == '0);
            compare_value("cp_ready", cp_ready, exp_ready);
        end
    endtask

    task automatic accept_command();
        rsp_pkt_t exp;
        logic     is_read;
        logic     suppressed;
        cmd_taken = 1'b0;
        if (cp_valid && cp_ready) begin
            cmd_taken = 1'b1;
            accepted_count++;
            is_read    = (cp_data.kind == OP_READ);
            suppressed = (cp_data.byteen == '0);
            if (suppressed) begin
                suppressed_count++;
            end else begin
                compare_value("m0.read", m0.read, is_read);
                compare_value("m0.write", m0.write, !is_read);
                check_condition(!m0_waitrequest, "command accepted while m0 was stalled");
            end
            case (cp_data.kind)
                OP_READ:            read_count++;
                OP_WRITE_NONPOSTED: nonposted_count++;
                default:            posted_count++;
            endcase
            // posted writes expect nothing back
            if (cp_data.kind != OP_WRITE_POSTED) begin
                exp.kind    = cp_data.kind;
                exp.addr    = cp_data.addr;
                exp.byteen  = cp_data.byteen;
                exp.data    = (is_read && !suppressed) ? mem[cp_data.addr[7:2]] : '0;
                exp.src_id  = cp_data.dest_id;
                exp.dest_id = cp_data.src_id;
                exp_q.push_back(exp);
            end
        end
    endtask

    task automatic check_response();
        rsp_pkt_t exp;
        if (rp_valid) begin
            check_condition(exp_q.size() > 0, "rp_valid high with no response outstanding");
        end
        if (rp_valid && rp_ready) begin
            response_count++;
            if (exp_q.size() > 0) begin
                exp = exp_q.pop_front();
                compare_value("rp_data.kind", rp_data.kind, exp.kind);
                compare_value("rp_data.addr", rp_data.addr, exp.addr);
                compare_value("rp_data.byteen", rp_data.byteen, exp.byteen);
                compare_value("rp_data.data", rp_data.data, exp.data);
                compare_value("rp_data.src_id", rp_data.src_id, exp.src_id);
                compare_value("rp_data.dest_id", rp_data.dest_id, exp.dest_id);
            end
        end
    endtask

    // everything is sampled at the falling edge halfway between two drives
    always @(negedge clk) begin
        cycle_count++;
        if (!rst_n) begin
            cmd_taken = 1'b0;
            check_condition(!rp_valid, "rp_valid high during reset");
            check_condition(!(m0.read || m0.write), "m0 request during reset");
        end else begin
            check_slave_side();
            check_ready();
            check_response();
            accept_command();
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    always @(posedge clk) begin
        if (rst_n) begin
            // a command holds until it is taken, then a new one or a gap follows
            if (!cp_valid || cmd_taken) begin
                if (sent_count < NUM_CMDS && (next_rand() % 4) != 0) begin
                    cp_valid <= 1'b1;
                    cp_data  <= random_cmd();
                    sent_count++;
                end else begin
                    cp_valid <= 1'b0;
                end
            end
            m0_waitrequest <= ((next_rand() % 3) == 0);
            rp_ready       <= ((next_rand() % 4) != 0);
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle_count + 1) begin
                m0_readdatavalid <= 1'b1;
                m0_readdata      <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end else begin
                m0_readdatavalid <= 1'b0;
            end
        end
    end

    initial begin
        int i;
        int waited;
        rng_state        = SEED;
        rst_n            = 1'b0;
        cp_valid         = 1'b0;
        cp_data          = '0;
        m0_waitrequest   = 1'b0;
        m0_readdata      = '0;
        m0_readdatavalid = 1'b0;
        rp_ready         = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hA5C3_0000 ^ (i * 32'h0001_0203);
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        waited = 0;
        while (accepted_count < NUM_CMDS) begin
            @(posedge clk);
            waited++;
            if (waited > SEND_TIMEOUT) begin
                timeout_count++;
                $display("timeout: only %0d of %0d commands accepted",
                         accepted_count, NUM_CMDS);
                break;
            end
        end

        waited = 0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                timeout_count++;
                $display("timeout: %0d responses never arrived", exp_q.size());
                break;
            end
        end

        // idle cycles so that a stray extra response would still be caught
        repeat (8) @(posedge clk);
        check_condition(exp_q.size() == 0, "expected responses left over at the end");
        check_condition(response_count == read_count + nonposted_count,
                        $sformatf("got %0d responses for %0d reads and %0d non-posted writes",
                                  response_count, read_count, nonposted_count));
        check_condition(suppressed_count > 0 && posted_count > 0,
                        "stimulus produced no suppressed command or no posted write");

        $display("errors: %0d mismatches, %0d other failures, %0d timeouts, %0d assertions",
                 mismatch_count, failure_count, timeout_count,
                 dut0.u_asserts.assert_failures);
        if (mismatch_count + failure_count + timeout_count == 0 &&
            dut0.u_asserts.assert_failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/slave_agent_asserts.sv
`default_nettype none

`include "slave_agent_settings.svh"

module slave_agent_asserts
    import slave_agent_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input mm_cmd_t  m0,
    input logic     rp_valid,
    input logic     rp_ready,
    input rsp_pkt_t rp_data,
    input logic     rd_push,
    input logic     rd_full
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions so far
    int unsigned assert_failures = 0;

    // ------------------------------------------------------------
    // m0 command
    // ------------------------------------------------------------

    m0_single_op: assert property (@(posedge clk) disable iff (!rst_n)
        !(m0.read && m0.write))
        else begin
            assert_failures++;
            $error("m0 read and write asserted in the same cycle");
        end

    // the slave is only ever addressed by whole words
    m0_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (m0.read || m0.write) |-> (m0.address[`SA_MASK_BITS-1:0] == '0))
        else begin
            assert_failures++;
            $error("m0 address has masked bits set");
        end

    // ------------------------------------------------------------
    // response stream and read-data FIFO
    // ------------------------------------------------------------

    rp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rp_valid && !rp_ready) |=> (rp_valid && $stable(rp_data)))
        else begin
            assert_failures++;
            $error("response changed or dropped under back-pressure");
        end

    // read data arrives from the slave whenever it likes, so only the token
    // accounting of the design keeps this FIFO from overflowing
    rd_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        rd_push |-> !rd_full)
        else begin
            assert_failures++;
            $error("read data pushed into a full FIFO");
        end

endmodule

`default_nettype wire

// File: source/slave_agent.sv
`default_nettype none

`include "slave_agent_settings.svh"

module slave_agent
    import slave_agent_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cp_valid,
    input  cmd_pkt_t              cp_data,
    output logic                  cp_ready,
    output mm_cmd_t               m0,
    input  logic                  m0_waitrequest,
    input  logic [`SA_DATA_W-1:0] m0_readdata,
    input  logic                  m0_readdatavalid,
    output logic                  rp_valid,
    output rsp_pkt_t              rp_data,
    input  logic                  rp_ready
);

    logic                  tok_push;
    rsp_token_t            tok_data;
    rsp_token_t            tok_head;
    logic                  tok_pop;
    logic                  tok_empty;
    logic                  tok_full;
    logic [`SA_DATA_W-1:0] rd_head;
    logic                  rd_pop;
    logic                  rd_empty;
    logic                  rd_full;

    // ------------------------------------------------------------
    // input side
    // ------------------------------------------------------------

    cmd_decoder u_cmd_decoder (
        .cp_valid       (cp_valid),
        .cp_data        (cp_data),
        .cp_ready       (cp_ready),
        .m0             (m0),
        .m0_waitrequest (m0_waitrequest),
        .tok_push       (tok_push),
        .tok_data       (tok_data),
        .tok_full       (tok_full)
    );

    // ------------------------------------------------------------
    // token and read-data FIFOs
    // ------------------------------------------------------------

    sync_fifo #(
        .DEPTH  (`SA_FIFO_DEPTH),
        .item_t (rsp_token_t)
    ) u_tok_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tok_push),
        .push_data (tok_data),
        .pop       (tok_pop),
        .head      (tok_head),
        .empty     (tok_empty),
        .full      (tok_full)
    );

    // each issued read holds a token until its data is popped, and both FIFOs
    // are equally deep, so rd_full is never set when a data word arrives
    sync_fifo #(
        .DEPTH  (`SA_FIFO_DEPTH),
        .item_t (logic [`SA_DATA_W-1:0])
    ) u_rd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (m0_readdatavalid),
        .push_data (m0_readdata),
        .pop       (rd_pop),
        .head      (rd_head),
        .empty     (rd_empty),
        .full      (rd_full)
    );

    // output side
    rsp_builder u_rsp_builder (
        .tok_head  (tok_head),
        .tok_empty (tok_empty),
        .tok_pop   (tok_pop),
        .rd_head   (rd_head),
        .rd_empty  (rd_empty),
        .rd_pop    (rd_pop),
        .rp_valid  (rp_valid),
        .rp_data   (rp_data),
        .rp_ready  (rp_ready)
    );

endmodule

`default_nettype wire

// File: source/rsp_builder.sv
`default_nettype none

`include "slave_agent_settings.svh"

module rsp_builder
    import slave_agent_pkg::*;
(
    input  rsp_token_t            tok_head,
    input  logic                  tok_empty,
    output logic                  tok_pop,
    input  logic [`SA_DATA_W-1:0] rd_head,
    input  logic                  rd_empty,
    output logic                  rd_pop,
    output logic                  rp_valid,
    output rsp_pkt_t              rp_data,
    input  logic                  rp_ready
);

    logic rsp_xfer;

    // ------------------------------------------------------------
    // response readiness
    // ------------------------------------------------------------

    // tokens leave in command order, so the head token is always the next
    // response. a synthesized one can go at once, an issued read waits until
    // its data word has come back from the slave
    assign rp_valid = ~tok_empty & (tok_head.synth | ~rd_empty);

    // the slave returns read data in order, so the oldest data word always
    // belongs to the oldest issued read still waiting at the token head

    assign rsp_xfer = rp_valid & rp_ready;

    // both heads stay put until the beat transfers, which is what keeps
    // rp_data stable under back-pressure
    assign tok_pop = rsp_xfer;

    // a synthesized response never consumed a data word, so it must leave the
    // data FIFO alone for the read queued behind it
    assign rd_pop  = rsp_xfer & ~tok_head.synth;

    // ------------------------------------------------------------
    // packet assembly
    // ------------------------------------------------------------

    always_comb begin
        rp_data.kind    = tok_head.kind;
        rp_data.addr    = tok_head.addr;
        rp_data.byteen  = tok_head.byteen;

        // write responses and suppressed reads return an all-zero data word
        rp_data.data    = tok_head.synth ? '0 : rd_head;

        // the response travels back to whoever sent the command, so the
        // slave becomes the source and the master the destination
        rp_data.src_id  = tok_head.dest_id;
        rp_data.dest_id = tok_head.src_id;
    end

endmodule

`default_nettype wire

// File: source/cmd_decoder.sv
`default_nettype none

`include "slave_agent_settings.svh"

module cmd_decoder
    import slave_agent_pkg::*;
(
    input  logic       cp_valid,
    input  cmd_pkt_t   cp_data,
    output logic       cp_ready,
    output mm_cmd_t    m0,
    input  logic       m0_waitrequest,
    output logic       tok_push,
    output rsp_token_t tok_data,
    input  logic       tok_full
);

    // the decoder holds no state of its own, every outstanding command
    // is remembered by the token it leaves in the response FIFO

    logic is_read;
    logic is_write;
    logic is_nonposted;
    logic suppressed;
    logic issue;

    // ------------------------------------------------------------
    // command decode
    // ------------------------------------------------------------

    assign is_read      = (cp_data.kind == OP_READ);
    assign is_nonposted = (cp_data.kind == OP_WRITE_NONPOSTED);
    assign is_write     = (cp_data.kind == OP_WRITE_POSTED) | is_nonposted;

    // a command with no byte enabled would do nothing useful at the slave,
    // so it never reaches m0 and any response it needs is synthesized
    assign suppressed = ~|cp_data.byteen;

    // every command stalls once the token FIFO is full, even a posted write
    // that would not need a slot, which keeps the ready path short
    assign cp_ready = ~tok_full & (~m0_waitrequest | suppressed);

    // the slave only sees a request while there is room for its token
    assign issue = cp_valid & ~tok_full & ~suppressed;

    // ------------------------------------------------------------
    // memory-mapped command
    // ------------------------------------------------------------

    always_comb begin
        m0.read       = issue & is_read;
        m0.write      = issue & is_write;
        // narrow accesses keep their byte address in the packet, but the slave
        // is addressed by whole words
        m0.address    = {cp_data.addr[`SA_ADDR_W-1:`SA_MASK_BITS], {`SA_MASK_BITS{1'b0}}};
        m0.byteenable = cp_data.byteen;
        m0.writedata  = cp_data.data;
    end

    // ------------------------------------------------------------
    // response token
    // ------------------------------------------------------------

    // reads always get a response, suppressed or not, and so do non-posted writes
    assign tok_push = cp_valid & cp_ready & (is_read | is_nonposted);

    always_comb begin
        tok_data.kind    = cp_data.kind;
        // the response reports the address as the master sent it, unmasked
        tok_data.addr    = cp_data.addr;
        tok_data.byteen  = cp_data.byteen;
        tok_data.src_id  = cp_data.src_id;
        tok_data.dest_id = cp_data.dest_id;
        // write responses carry no data, and a suppressed read has no slave
        // data coming back, so both are answered from the token alone
        tok_data.synth   = (is_read & suppressed) | is_nonposted;
    end

endmodule

`default_nettype wire

// File: source/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter int  DEPTH  = 4,
    parameter type item_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  item_t push_data,
    input  logic  pop,
    output item_t head,
    output logic  empty,
    output logic  full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // a push into a full FIFO or a pop from an empty one is ignored
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // storage only, the occupancy count says which entries are valid
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fall-through head read straight out of the storage registers, so a new
    // entry shows one cycle after its push and push_data never reaches head
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: source/slave_agent_pkg.sv
`default_nettype none

`include "slave_agent_settings.svh"

package slave_agent_pkg;

    // kind of transaction carried by a packet
    // posted writes never get a response, non-posted writes always do
    typedef enum logic [1:0] {
        OP_READ            = 2'd0,
        OP_WRITE_POSTED    = 2'd1,
        OP_WRITE_NONPOSTED = 2'd2
    } trans_kind_e;

    // command packet as it arrives from the fabric
    typedef struct packed {
        trans_kind_e             kind;
        logic [`SA_ADDR_W-1:0] addr;
        logic [`SA_BE_W-1:0]   byteen;
        logic [`SA_DATA_W-1:0] data;
        logic [`SA_ID_W-1:0]   src_id;
        logic [`SA_ID_W-1:0]   dest_id;
    } cmd_pkt_t;

    // everything the response side needs to know about a command
    // synth marks a response that is built without any slave read data
    typedef struct packed {
        trans_kind_e             kind;
        logic [`SA_ADDR_W-1:0] addr;
        logic [`SA_BE_W-1:0]   byteen;
        logic [`SA_ID_W-1:0]   src_id;
        logic [`SA_ID_W-1:0]   dest_id;
        logic                    synth;
    } rsp_token_t;

    // response packet sent back into the fabric
    typedef struct packed {
        trans_kind_e             kind;
        logic [`SA_ADDR_W-1:0] addr;
        logic [`SA_BE_W-1:0]   byteen;
        logic [`SA_DATA_W-1:0] data;
        logic [`SA_ID_W-1:0]   src_id;
        logic [`SA_ID_W-1:0]   dest_id;
    } rsp_pkt_t;

    // single-beat command to the memory-mapped slave
    typedef struct packed {
        logic                    read;
        logic                    write;
        logic [`SA_ADDR_W-1:0] address;
        logic [`SA_BE_W-1:0]   byteenable;
        logic [`SA_DATA_W-1:0] writedata;
    } mm_cmd_t;

endpackage

`default_nettype wire

// File: include/slave_agent_settings.svh
`ifndef SLAVE_AGENT_SETTINGS_SVH
`define SLAVE_AGENT_SETTINGS_SVH

// ------------------------------------------------------------
// widths of the command and response packets and of m0
// ------------------------------------------------------------

// byte address width, the same on the packet and on the slave
`define SA_ADDR_W 32

// width of one data word on the slave
`define SA_DATA_W 32

// one byte enable per 8-bit symbol, so this is also the symbol count
`define SA_BE_W (`SA_DATA_W / 8)

// width of the source and destination ID fields
`define SA_ID_W 3

// low address bits cleared so the slave sees word-aligned addresses
`define SA_MASK_BITS 2

// entries in each internal FIFO, which bounds the outstanding responses
`define SA_FIFO_DEPTH 4

`endif
